/* rtl/riscv_defines.svh */
`ifndef RISCV_DEFINES_SVH
`define RISCV_DEFINES_SVH

// Datapath and address width
`define XLEN 32

// Register index width and count
`define REG_ADDR_W 5
`define NUM_REGS 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

/* rtl/riscv_isa_pkg.sv */
`default_nettype none

package riscv_isa_pkg;

  // ====================
  // Major opcodes
  // ====================
  typedef enum logic [6:0] {
    opc_load   = 7'b0000011,
    opc_op_imm = 7'b0010011,
    opc_auipc  = 7'b0010111,
    opc_store  = 7'b0100011,
    opc_op     = 7'b0110011,
    opc_lui    = 7'b0110111,
    opc_branch = 7'b1100011,
    opc_jalr   = 7'b1100111,
    opc_jal    = 7'b1101111
  } opcode_e;

  // Branch codes overlap the ALU codes, so they are aliases below
  typedef enum logic [2:0] {
    f3_add_sub = 3'b000,
    f3_sll     = 3'b001,
    f3_lw_sw   = 3'b010,
    f3_blt     = 3'b100,
    f3_srl     = 3'b101
  } funct3_e;

  localparam funct3_e f3_beq = f3_add_sub;
  localparam funct3_e f3_bne = f3_sll;
  localparam funct3_e f3_bge = f3_srl;

  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_sub  = 7'b0100000;
  localparam logic [6:0] funct7_mul  = 7'b0000001;  // M extension

  // Fixed R-type field layout, other formats reuse these slices
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    funct3_e    funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } instr_t;

endpackage

`default_nettype wire

/* rtl/pipe_pkg.sv */
`default_nettype none

`include "riscv_defines.svh"

package pipe_pkg;

  import riscv_isa_pkg::*;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_mul,
    alu_sll,
    alu_srl,
    alu_pass_b,   // LUI
    alu_pc_add    // AUIPC
  } alu_op_e;

  typedef enum logic [1:0] {
    fwd_none,
    fwd_from_mem,
    fwd_from_wb
  } fwd_sel_e;

  // ====================
  // Stage payloads
  // ====================
  typedef struct packed {
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       rs1_val;
    logic [`XLEN-1:0]       rs2_val;
    logic [`REG_ADDR_W-1:0] rs1_idx;  // Zero when the source is unused
    logic [`REG_ADDR_W-1:0] rs2_idx;
    logic [`XLEN-1:0]       imm;
    logic [`REG_ADDR_W-1:0] rd;
    alu_op_e                alu_op;
    logic                   use_imm;
    logic                   reg_write;
    logic                   mem_read;
    logic                   mem_write;
    logic                   is_branch;
    funct3_e                funct3;
    logic                   is_jal;
    logic                   is_jalr;
  } id_ex_t;

  typedef struct packed {
    logic [`XLEN-1:0]       result;      // ALU result, link value or address
    logic [`XLEN-1:0]       store_data;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   reg_write;
    logic                   mem_read;
    logic                   mem_write;
  } ex_mem_t;

  // MEM/WB register and retire port
  typedef struct packed {
    logic                   valid;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       value;
  } wb_t;

  typedef struct packed {
    logic             read;
    logic             write;
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] wdata;
  } dmem_req_t;

endpackage

`default_nettype wire

/* rtl/reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

`include "riscv_defines.svh"

module reg_file import pipe_pkg::*; (
  input  wire logic                   clock,
  input  wire logic                   reset,
  input  wire logic [`REG_ADDR_W-1:0] rs1_addr,
  input  wire logic [`REG_ADDR_W-1:0] rs2_addr,
  output logic      [`XLEN-1:0]       rs1_data,
  output logic      [`XLEN-1:0]       rs2_data,
  input  wire wb_t                    wr
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.valid && (wr.rd != '0)) begin
      regs[wr.rd] <= wr.value;
    end
  end

  // Write-through so decode sees the value retiring this cycle
  assign rs1_data = (wr.valid && (wr.rd != '0) && (wr.rd == rs1_addr)) ? wr.value
                                                                       : regs[rs1_addr];
  assign rs2_data = (wr.valid && (wr.rd != '0) && (wr.rd == rs2_addr)) ? wr.value
                                                                       : regs[rs2_addr];

  x0_reads_zero: assert property (@(posedge clock) disable iff (reset)
    ((rs1_addr != '0) || (rs1_data == '0)) && ((rs2_addr != '0) || (rs2_data == '0)));

endmodule

`default_nettype wire

/* rtl/decode_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "riscv_defines.svh"

module decode_stage import riscv_isa_pkg::*, pipe_pkg::*; (
  input  wire logic                   clock,
  input  wire logic                   reset,
  input  wire logic                   stall,
  input  wire logic                   flush,
  input  wire logic [`XLEN-1:0]       fetch_pc,
  input  wire instr_t                 fetch_instr,
  input  wire wb_t                    wb,
  output id_ex_t                      id_ex,
  output logic      [`REG_ADDR_W-1:0] rs1_idx,
  output logic      [`REG_ADDR_W-1:0] rs2_idx
);

  logic [`XLEN-1:0] if_id_pc;
  instr_t           if_id_instr;
  logic             if_id_valid;
  logic [31:0]      raw;
  logic [`XLEN-1:0] imm_i, imm_s, imm_b, imm_j, imm_u;
  logic [`XLEN-1:0] rs1_data, rs2_data;
  id_ex_t           dec;
  logic             known, uses_rs1, uses_rs2;

  // ====================
  // IF/ID register
  // ====================
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      if_id_valid <= 1'b0;
    end else if (flush) begin
      if_id_valid <= 1'b0;  // Wrong-path fetch
    end else if (!stall) begin
      if_id_valid <= 1'b1;
      if_id_pc    <= fetch_pc;
      if_id_instr <= fetch_instr;
    end
  end

  assign raw   = if_id_instr;
  assign imm_i = {{20{raw[31]}}, raw[31:20]};
  assign imm_s = {{20{raw[31]}}, raw[31:25], raw[11:7]};
  assign imm_b = {{19{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};
  assign imm_j = {{11{raw[31]}}, raw[31], raw[19:12], raw[20], raw[30:21], 1'b0};
  assign imm_u = {raw[31:12], 12'b0};

  // ====================
  // Control decode
  // ====================
  always_comb begin
    dec        = '0;
    known      = 1'b1;
    uses_rs1   = 1'b0;
    uses_rs2   = 1'b0;
    dec.pc     = if_id_pc;
    dec.rd     = if_id_instr.rd;
    dec.funct3 = if_id_instr.funct3;
    dec.alu_op = alu_add;
    case (if_id_instr.opcode)
      opc_op_imm: begin
        uses_rs1      = 1'b1;
        dec.use_imm   = 1'b1;
        dec.reg_write = 1'b1;
        dec.imm       = imm_i;
        case (if_id_instr.funct3)
          f3_add_sub: dec.alu_op = alu_add;
          f3_sll:     dec.alu_op = alu_sll;
          f3_srl:     dec.alu_op = alu_srl;
          default:    known = 1'b0;
        endcase
        if ((if_id_instr.funct3 != f3_add_sub) && (if_id_instr.funct7 != funct7_base)) begin
          known = 1'b0;  // SRAI and friends
        end
      end
      opc_op: begin
        uses_rs1      = 1'b1;
        uses_rs2      = 1'b1;
        dec.reg_write = 1'b1;
        if (if_id_instr.funct3 != f3_add_sub)         known = 1'b0;
        else if (if_id_instr.funct7 == funct7_base)   dec.alu_op = alu_add;
        else if (if_id_instr.funct7 == funct7_sub)    dec.alu_op = alu_sub;
        else if (if_id_instr.funct7 == funct7_mul)    dec.alu_op = alu_mul;
        else                                          known = 1'b0;
      end
      opc_load, opc_store: begin
        uses_rs1      = 1'b1;
        uses_rs2      = (if_id_instr.opcode == opc_store);
        dec.use_imm   = 1'b1;
        dec.mem_read  = (if_id_instr.opcode == opc_load);
        dec.reg_write = (if_id_instr.opcode == opc_load);
        dec.mem_write = (if_id_instr.opcode == opc_store);
        dec.imm       = (if_id_instr.opcode == opc_store) ? imm_s : imm_i;
        known         = (if_id_instr.funct3 == f3_lw_sw);
      end
      opc_branch: begin
        uses_rs1      = 1'b1;
        uses_rs2      = 1'b1;
        dec.is_branch = 1'b1;
        dec.imm       = imm_b;
        case (if_id_instr.funct3)
          f3_beq, f3_bne, f3_blt, f3_bge: known = 1'b1;
          default:                        known = 1'b0;
        endcase
      end
      opc_jal: begin
        dec.is_jal    = 1'b1;
        dec.reg_write = 1'b1;
        dec.imm       = imm_j;
      end
      opc_jalr: begin
        uses_rs1      = 1'b1;
        dec.is_jalr   = 1'b1;
        dec.reg_write = 1'b1;
        dec.imm       = imm_i;
      end
      opc_lui, opc_auipc: begin
        dec.use_imm   = 1'b1;
        dec.reg_write = 1'b1;
        dec.imm       = imm_u;
        dec.alu_op    = (if_id_instr.opcode == opc_lui) ? alu_pass_b : alu_pc_add;
      end
      default: known = 1'b0;
    endcase
    dec.reg_write = dec.reg_write && (if_id_instr.rd != '0);  // x0 writes vanish here
    dec.rs1_idx   = uses_rs1 ? if_id_instr.rs1 : '0;
    dec.rs2_idx   = uses_rs2 ? if_id_instr.rs2 : '0;
  end

  assign rs1_idx = dec.rs1_idx;
  assign rs2_idx = dec.rs2_idx;

  reg_file u_reg_file (
    .clock    (clock),
    .reset    (reset),
    .rs1_addr (rs1_idx),
    .rs2_addr (rs2_idx),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr       (wb)
  );

  // ID/EX register, bubble on stall, flush or unknown opcode
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      id_ex <= '0;
    end else if (stall || flush || !if_id_valid || !known) begin
      id_ex <= '0;
    end else begin
      id_ex         <= dec;
      id_ex.rs1_val <= rs1_data;
      id_ex.rs2_val <= rs2_data;
    end
  end

endmodule

`default_nettype wire

/* rtl/hazard_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "riscv_defines.svh"

module hazard_unit import pipe_pkg::*; (
  input  wire logic [`REG_ADDR_W-1:0] rs1_idx,
  input  wire logic [`REG_ADDR_W-1:0] rs2_idx,
  input  wire id_ex_t                 id_ex,
  input  wire ex_mem_t                ex_mem,
  input  wire wb_t                    mem_wb,
  output logic                        stall,
  output fwd_sel_e                    fwd_a,
  output fwd_sel_e                    fwd_b
);

  logic mem_hit_a, mem_hit_b;
  logic wb_hit_a, wb_hit_b;

  // ====================
  // Forwarding to execute
  // ====================
  assign mem_hit_a = ex_mem.reg_write && (ex_mem.rd != '0) && (ex_mem.rd == id_ex.rs1_idx);
  assign mem_hit_b = ex_mem.reg_write && (ex_mem.rd != '0) && (ex_mem.rd == id_ex.rs2_idx);
  assign wb_hit_a  = mem_wb.valid && (mem_wb.rd != '0) && (mem_wb.rd == id_ex.rs1_idx);
  assign wb_hit_b  = mem_wb.valid && (mem_wb.rd != '0) && (mem_wb.rd == id_ex.rs2_idx);

  // Youngest producer wins
  assign fwd_a = mem_hit_a ? fwd_from_mem : (wb_hit_a ? fwd_from_wb : fwd_none);
  assign fwd_b = mem_hit_b ? fwd_from_mem : (wb_hit_b ? fwd_from_wb : fwd_none);

  // Load result not ready until the load reaches memory
  assign stall = id_ex.mem_read && (id_ex.rd != '0) &&
                 ((id_ex.rd == rs1_idx) || (id_ex.rd == rs2_idx));

  // A stalling load never redirects, so the held IF/ID entry is never flushed away
  always_comb begin
    assert final (!(stall && (id_ex.is_branch || id_ex.is_jal || id_ex.is_jalr)))
      else $error("load-use stall coincides with a redirect");
  end

endmodule

`default_nettype wire

/* rtl/execute_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "riscv_defines.svh"

module execute_stage import riscv_isa_pkg::*, pipe_pkg::*; (
  input  wire logic             clock,
  input  wire logic             reset,
  input  wire id_ex_t           id_ex,
  input  wire fwd_sel_e         fwd_a,
  input  wire fwd_sel_e         fwd_b,
  input  wire logic [`XLEN-1:0] mem_fwd_value,
  input  wire logic [`XLEN-1:0] wb_value,
  output ex_mem_t               ex_mem,
  output logic                  redirect,
  output logic      [`XLEN-1:0] redirect_pc
);

  logic [`XLEN-1:0] op_a, rs2_fwd, op_b;
  logic [`XLEN-1:0] alu_result, link;
  logic             is_jump, cond;

  // ====================
  // Operand select
  // ====================
  assign op_a    = (fwd_a == fwd_from_mem) ? mem_fwd_value :
                   (fwd_a == fwd_from_wb)  ? wb_value : id_ex.rs1_val;
  assign rs2_fwd = (fwd_b == fwd_from_mem) ? mem_fwd_value :
                   (fwd_b == fwd_from_wb)  ? wb_value : id_ex.rs2_val;
  assign op_b    = id_ex.use_imm ? id_ex.imm : rs2_fwd;

  always_comb begin
    case (id_ex.alu_op)
      alu_add:    alu_result = op_a + op_b;
      alu_sub:    alu_result = op_a - op_b;
      alu_mul:    alu_result = op_a * op_b;  // Low half only
      alu_sll:    alu_result = op_a << op_b[4:0];
      alu_srl:    alu_result = op_a >> op_b[4:0];
      alu_pass_b: alu_result = op_b;
      alu_pc_add: alu_result = id_ex.pc + op_b;
      default:    alu_result = '0;
    endcase
  end

  // ====================
  // Branch and jump
  // ====================
  always_comb begin
    case (id_ex.funct3)
      f3_beq:  cond = (op_a == rs2_fwd);
      f3_bne:  cond = (op_a != rs2_fwd);
      f3_blt:  cond = ($signed(op_a) < $signed(rs2_fwd));
      f3_bge:  cond = ($signed(op_a) >= $signed(rs2_fwd));
      default: cond = 1'b0;
    endcase
  end

  assign is_jump     = id_ex.is_jal || id_ex.is_jalr;
  assign link        = id_ex.pc + `XLEN'd4;
  assign redirect    = (id_ex.is_branch && cond) || is_jump;
  assign redirect_pc = id_ex.is_jalr ? ((op_a + id_ex.imm) & ~`XLEN'd1)
                                     : (id_ex.pc + id_ex.imm);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      ex_mem <= '0;
    end else begin
      ex_mem.result     <= is_jump ? link : alu_result;
      ex_mem.store_data <= rs2_fwd;
      ex_mem.rd         <= id_ex.rd;
      ex_mem.reg_write  <= id_ex.reg_write;
      ex_mem.mem_read   <= id_ex.mem_read;
      ex_mem.mem_write  <= id_ex.mem_write;
    end
  end

endmodule

`default_nettype wire

/* rtl/riscv_pipeline.sv */
`timescale 1ns/100ps
`default_nettype none

`include "riscv_defines.svh"

module riscv_pipeline import riscv_isa_pkg::*, pipe_pkg::*; (
  input  wire logic             clock,
  input  wire logic             reset,
  output logic      [`XLEN-1:0] imem_addr,
  input  wire logic [31:0]      imem_data,
  output dmem_req_t             dmem_req,
  input  wire logic [`XLEN-1:0] dmem_rdata,
  output wb_t                   retire
);

  logic [`XLEN-1:0]       pc;
  logic                   stall;
  logic                   redirect;
  logic [`XLEN-1:0]       redirect_pc;
  logic [`REG_ADDR_W-1:0] rs1_idx, rs2_idx;
  fwd_sel_e               fwd_a, fwd_b;
  id_ex_t                 id_ex;
  ex_mem_t                ex_mem;
  wb_t                    mem_wb;
  logic [`XLEN-1:0]       mem_fwd_value;

  // ====================
  // Fetch
  // ====================
  always_ff @(posedge clock or posedge reset) begin
    if (reset)         pc <= `RESET_PC;
    else if (redirect) pc <= redirect_pc;  // Beats stall
    else if (!stall)   pc <= pc + `XLEN'd4;
  end

  assign imem_addr = pc;

  decode_stage u_decode_stage (
    .clock       (clock),
    .reset       (reset),
    .stall       (stall),
    .flush       (redirect),
    .fetch_pc    (pc),
    .fetch_instr (instr_t'(imem_data)),
    .wb          (mem_wb),
    .id_ex       (id_ex),
    .rs1_idx     (rs1_idx),
    .rs2_idx     (rs2_idx)
  );

  hazard_unit u_hazard_unit (
    .rs1_idx (rs1_idx),
    .rs2_idx (rs2_idx),
    .id_ex   (id_ex),
    .ex_mem  (ex_mem),
    .mem_wb  (mem_wb),
    .stall   (stall),
    .fwd_a   (fwd_a),
    .fwd_b   (fwd_b)
  );

  execute_stage u_execute_stage (
    .clock         (clock),
    .reset         (reset),
    .id_ex         (id_ex),
    .fwd_a         (fwd_a),
    .fwd_b         (fwd_b),
    .mem_fwd_value (mem_fwd_value),
    .wb_value      (mem_wb.value),
    .ex_mem        (ex_mem),
    .redirect      (redirect),
    .redirect_pc   (redirect_pc)
  );

  // ====================
  // Memory and writeback
  // ====================
  assign dmem_req.read  = ex_mem.mem_read;
  assign dmem_req.write = ex_mem.mem_write;
  assign dmem_req.addr  = ex_mem.result;
  assign dmem_req.wdata = ex_mem.store_data;

  assign mem_fwd_value = ex_mem.mem_read ? dmem_rdata : ex_mem.result;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mem_wb <= '0;
    end else begin
      mem_wb.valid <= ex_mem.reg_write && (ex_mem.rd != '0);
      mem_wb.rd    <= ex_mem.rd;
      mem_wb.value <= mem_fwd_value;
    end
  end

  assign retire = mem_wb;

  one_mem_op: assert property (@(posedge clock) disable iff (reset)
    !(dmem_req.read && dmem_req.write));

endmodule

`default_nettype wire

/* testbench/tb_tests.svh */
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

// ====================
// Instruction encoders
// ====================
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input funct3_e f3,
                                      input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, opc_op};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input funct3_e f3, input logic [4:0] rd,
                                      input opcode_e opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
  return {imm[11:5], rs2, rs1, f3_lw_sw, imm[4:0], opc_store};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input funct3_e f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input opcode_e opc);
  return {imm, rd, opc};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
endfunction

function automatic logic [31:0] sext12(input logic [11:0] v);
  return {{20{v[11]}}, v};
endfunction

// ====================
// Program and expectation helpers
// ====================
task automatic clear_program();
  for (logic [8:0] i = 9'd0; i < 9'd256; i++) begin
    imem[i[7:0]] = 32'h0000_0000;  // Unknown opcode, bubble
  end
  prog_pc = `RESET_PC;
  exp_retire.delete();
  exp_store.delete();
endtask

task automatic emit(input logic [31:0] word);
  imem[prog_pc[9:2]] = word;
  prog_pc = prog_pc + 32'd4;
endtask

task automatic emit_addi(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
  emit(enc_i(imm, rs1, f3_add_sub, rd, opc_op_imm));
endtask

task automatic emit_halt();
  emit(enc_j(21'd0, 5'd0));  // JAL x0, 0
endtask

task automatic expect_write(input logic [4:0] rd, input logic [31:0] value);
  wb_t w;
  w.valid = 1'b1;
  w.rd    = rd;
  w.value = value;
  exp_retire.push_back(w);
endtask

task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
  dmem_req_t s;
  s.read  = 1'b0;
  s.write = 1'b1;
  s.addr  = addr;
  s.wdata = data;
  exp_store.push_back(s);
endtask

// ====================
// Directed tests
// ====================
task automatic reset_test();
  dmem_req_t exp;
  int        cycles;
  clear_program();
  emit_addi(5'd1, 5'd0, 12'd5);
  emit(enc_s(12'd0, 5'd1, 5'd0));  // SW x1, 0(x0) in a tight loop
  emit(enc_j(21'h1f_fffc, 5'd0));
  apply_reset();
  exp.read  = 1'b0;
  exp.write = 1'b1;
  exp.addr  = 32'd0;
  exp.wdata = 32'd5;
  cycles    = 0;
  while (!dmem_req.write && cycles < 50) begin
    @(negedge clock);
    cycles++;
  end
  if (dmem_req.write) begin
    check_store(dmem_req, exp);
  end else begin
    fail_count++;
    $display("Timeout at %0t: the store loop never wrote memory", $time);
  end
  apply_reset();  // Reset in the middle of the store loop
endtask

task automatic arith_chain_test();
  logic [31:0] r;
  logic [11:0] imm_a, imm_b;
  logic [4:0]  sh_l, sh_r;
  logic [19:0] upper;
  logic [31:0] x1, x2, x3, x4, x5, x6, x7, x8, x9, x10, x11;
  r     = $random(seed);
  imm_a = r[11:0];
  r     = $random(seed);
  imm_b = r[11:0];
  r     = $random(seed);
  sh_l  = r[4:0];
  sh_r  = r[9:5];
  upper = r[31:12];
  clear_program();
  x1  = sext12(imm_a);
  x2  = x1 + sext12(imm_b);
  x3  = x2 + x1;
  x4  = x3 - x2;
  x5  = x4 * x3;  // Low 32 bits
  x6  = x5 << sh_l;
  x7  = x6 >> sh_r;
  x8  = {upper, 12'h000};
  emit_addi(5'd1, 5'd0, imm_a);
  emit_addi(5'd2, 5'd1, imm_b);
  emit(enc_r(funct7_base, 5'd1, 5'd2, f3_add_sub, 5'd3));
  emit(enc_r(funct7_sub, 5'd2, 5'd3, f3_add_sub, 5'd4));
  emit(enc_r(funct7_mul, 5'd3, 5'd4, f3_add_sub, 5'd5));
  emit(enc_i({7'd0, sh_l}, 5'd5, f3_sll, 5'd6, opc_op_imm));
  emit(enc_i({7'd0, sh_r}, 5'd6, f3_srl, 5'd7, opc_op_imm));
  emit(enc_u(upper, 5'd8, opc_lui));
  x9 = prog_pc + {~upper, 12'h000};  // AUIPC adds its own pc
  emit(enc_u(~upper, 5'd9, opc_auipc));
  x10 = x8 + x7;
  x11 = x9 - x10;
  emit(enc_r(funct7_base, 5'd7, 5'd8, f3_add_sub, 5'd10));
  emit(enc_r(funct7_sub, 5'd10, 5'd9, f3_add_sub, 5'd11));
  emit_halt();
  expect_write(5'd1, x1);
  expect_write(5'd2, x2);
  expect_write(5'd3, x3);
  expect_write(5'd4, x4);
  expect_write(5'd5, x5);
  expect_write(5'd6, x6);
  expect_write(5'd7, x7);
  expect_write(5'd8, x8);
  expect_write(5'd9, x9);
  expect_write(5'd10, x10);
  expect_write(5'd11, x11);
  apply_reset();
  collect_events(200);
endtask

task automatic load_store_test();
  logic [31:0] r;
  logic [11:0] imm;
  logic [31:0] x1, x5;
  r   = $random(seed);
  imm = r[11:0];
  x1  = sext12(imm);
  x5  = dmem_fill(8'd20);  // Word at 0x50, untouched by the store
  clear_program();
  emit_addi(5'd1, 5'd0, imm);
  emit_addi(5'd2, 5'd0, 12'h040);
  emit(enc_s(12'd8, 5'd1, 5'd2));
  emit(enc_i(12'd8, 5'd2, f3_lw_sw, 5'd3, opc_load));
  emit(enc_r(funct7_base, 5'd1, 5'd3, f3_add_sub, 5'd4));  // Load-use on x3
  emit(enc_i(12'd16, 5'd2, f3_lw_sw, 5'd5, opc_load));
  emit(enc_r(funct7_base, 5'd4, 5'd5, f3_add_sub, 5'd6));
  emit_halt();
  expect_write(5'd1, x1);
  expect_write(5'd2, 32'h0000_0040);
  expect_store(32'h0000_0048, x1);
  expect_write(5'd3, x1);
  expect_write(5'd4, x1 + x1);
  expect_write(5'd5, x5);
  expect_write(5'd6, x5 + x1 + x1);
  apply_reset();
  collect_events(200);
endtask

// Branch over two markers onto a third
task automatic branch_case(input funct3_e f3, input logic [4:0] rs1, input logic [4:0] rs2,
                           input logic taken, input logic [11:0] tag);
  emit(enc_b(13'd12, rs2, rs1, f3));
  emit_addi(5'd20, 5'd0, tag);
  emit_addi(5'd21, 5'd0, tag + 12'd1);
  emit_addi(5'd22, 5'd0, tag + 12'd2);
  if (!taken) begin
    expect_write(5'd20, sext12(tag));
    expect_write(5'd21, sext12(tag + 12'd1));
  end
  expect_write(5'd22, sext12(tag + 12'd2));
endtask

task automatic branch_test();
  clear_program();
  emit_addi(5'd1, 5'd0, 12'hffb);  // x1 = -5
  emit_addi(5'd2, 5'd0, 12'd3);    // x2 = 3
  emit_addi(5'd3, 5'd0, 12'hffb);  // x3 = -5
  expect_write(5'd1, 32'hffff_fffb);
  expect_write(5'd2, 32'd3);
  expect_write(5'd3, 32'hffff_fffb);
  branch_case(f3_beq, 5'd1, 5'd3, 1'b1, 12'd16);  // -5 == -5
  branch_case(f3_beq, 5'd1, 5'd2, 1'b0, 12'd32);
  branch_case(f3_bne, 5'd1, 5'd2, 1'b1, 12'd48);
  branch_case(f3_bne, 5'd1, 5'd3, 1'b0, 12'd64);
  branch_case(f3_blt, 5'd1, 5'd2, 1'b1, 12'd80);  // Signed, -5 < 3
  branch_case(f3_blt, 5'd2, 5'd1, 1'b0, 12'd96);
  branch_case(f3_bge, 5'd2, 5'd1, 1'b1, 12'd112);
  branch_case(f3_bge, 5'd1, 5'd2, 1'b0, 12'd128);
  branch_case(f3_bge, 5'd1, 5'd3, 1'b1, 12'd144);  // Equal counts as taken
  emit_halt();
  apply_reset();
  collect_events(400);
endtask

task automatic jump_test();
  logic [31:0] x5, x6, x7, target;
  clear_program();
  x5 = prog_pc + 32'd4;
  emit(enc_j(21'd16, 5'd5));  // JAL x5, +16
  emit_addi(5'd20, 5'd0, 12'd1);
  emit_addi(5'd21, 5'd0, 12'd2);
  emit_addi(5'd22, 5'd0, 12'd3);
  x6 = 32'd45;
  emit_addi(5'd6, 5'd0, 12'd45);
  x7     = prog_pc + 32'd4;
  target = (x6 + 32'd4) & ~32'd1;  // Odd sum, bit 0 dropped
  emit(enc_i(12'd4, 5'd6, f3_add_sub, 5'd7, opc_jalr));
  while (prog_pc < target) begin
    emit_addi(5'd23, 5'd0, 12'd7);  // Wrong path filler
  end
  emit(enc_u(20'd0, 5'd9, opc_auipc));  // Reports the pc it landed on
  emit(enc_r(funct7_base, 5'd5, 5'd7, f3_add_sub, 5'd8));
  emit_halt();
  expect_write(5'd5, x5);
  expect_write(5'd6, x6);
  expect_write(5'd7, x7);
  expect_write(5'd9, target);
  expect_write(5'd8, x7 + x5);
  apply_reset();
  collect_events(200);
endtask

`endif

/* testbench/tb_riscv_pipeline.sv */
`timescale 1ns/100ps
`default_nettype none

`include "riscv_defines.svh"

module tb_riscv_pipeline import riscv_isa_pkg::*, pipe_pkg::*; ();

  logic             clock;
  logic             reset;
  logic [`XLEN-1:0] imem_addr;
  logic [31:0]      imem_data;
  dmem_req_t        dmem_req;
  logic [`XLEN-1:0] dmem_rdata;
  wb_t              retire;

  logic [31:0] imem [0:255];
  logic [31:0] dmem [0:255];

  wb_t              exp_retire[$];
  dmem_req_t        exp_store[$];
  logic [`XLEN-1:0] prog_pc;
  integer           seed;
  int               mismatch_count;
  int               fail_count;

  always #10 clock = ~clock;

  riscv_pipeline u_dut (
    .clock      (clock),
    .reset      (reset),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .retire     (retire)
  );

  // ====================
  // Memory models
  // ====================
  assign imem_data  = imem[imem_addr[9:2]];  // Word addressed, 1 KiB
  assign dmem_rdata = dmem_req.read ? dmem[dmem_req.addr[9:2]]
                                    : 32'hbad0_bad0;  // Idle bus returns junk

  function automatic logic [31:0] dmem_fill(input logic [7:0] idx);
    return 32'hc0de_0000 ^ ({24'd0, idx} * 32'h0101_0101);
  endfunction

  // Refilled on every reset
  always @(posedge clock or posedge reset) begin
    if (reset) begin
      for (logic [8:0] i = 9'd0; i < 9'd256; i++) begin
        dmem[i[7:0]] <= dmem_fill(i[7:0]);
      end
    end else if (dmem_req.write) begin
      dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
    end
  end

  // ====================
  // Compare tasks
  // ====================
  task automatic check_retire(input wb_t got, input wb_t exp);
    if (got.rd !== exp.rd) begin
      mismatch_count++;
      $display("Mismatch at %0t: retire.rd got x%0d expected x%0d", $time, got.rd, exp.rd);
    end
    if (got.value !== exp.value) begin
      mismatch_count++;
      $display("Mismatch at %0t: retire.value (x%0d) got %h expected %h",
               $time, exp.rd, got.value, exp.value);
    end
  endtask

  task automatic check_store(input dmem_req_t got, input dmem_req_t exp);
    if (got.read !== exp.read) begin
      mismatch_count++;
      $display("Mismatch at %0t: dmem_req.read got %b expected %b",
               $time, got.read, exp.read);
    end
    if (got.addr !== exp.addr) begin
      mismatch_count++;
      $display("Mismatch at %0t: dmem_req.addr got %h expected %h", $time, got.addr, exp.addr);
    end
    if (got.wdata !== exp.wdata) begin
      mismatch_count++;
      $display("Mismatch at %0t: dmem_req.wdata got %h expected %h",
               $time, got.wdata, exp.wdata);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [`XLEN-1:0] got,
                            input logic [`XLEN-1:0] exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // ====================
  // Reset and event collection
  // ====================
  task automatic apply_reset();
    int cycles;
    @(negedge clock);
    reset  = 1'b1;
    cycles = 0;
    while (cycles < 10) begin
      @(negedge clock);
      cycles++;
      check_flag("retire.valid", retire.valid, 1'b0);
      check_flag("dmem_req.write", dmem_req.write, 1'b0);
      check_word("imem_addr", imem_addr, `RESET_PC);
    end
    reset = 1'b0;
    @(negedge clock);
    check_flag("retire.valid", retire.valid, 1'b0);  // Pipeline still empty
    check_flag("dmem_req.write", dmem_req.write, 1'b0);
  endtask

  task automatic observe_outputs();
    if (retire.valid) begin
      if (exp_retire.size() == 0) begin
        fail_count++;
        $display("Unexpected retire at %0t: x%0d written with %h",
                 $time, retire.rd, retire.value);
      end else begin
        check_retire(retire, exp_retire.pop_front());
      end
    end
    if (dmem_req.write) begin
      if (exp_store.size() == 0) begin
        fail_count++;
        $display("Unexpected store at %0t: address %h data %h",
                 $time, dmem_req.addr, dmem_req.wdata);
      end else begin
        check_store(dmem_req, exp_store.pop_front());
      end
    end
  endtask

  task automatic collect_events(input int limit);
    int cycles;
    cycles = 0;
    while ((exp_retire.size() > 0 || exp_store.size() > 0) && cycles < limit) begin
      @(negedge clock);
      cycles++;
      observe_outputs();
    end
    if (exp_retire.size() > 0 || exp_store.size() > 0) begin
      fail_count++;
      $display("Timeout at %0t: %0d retires and %0d stores never arrived",
               $time, exp_retire.size(), exp_store.size());
    end
    // Quiet window, the self loop must add nothing
    cycles = 0;
    while (cycles < 12) begin
      @(negedge clock);
      cycles++;
      observe_outputs();
    end
  endtask

  `include "tb_tests.svh"

  initial begin
    seed           = 48385;
    mismatch_count = 0;
    fail_count     = 0;
    clock          = 1'b0;
    reset          = 1'b1;
    clear_program();
    reset_test();
    arith_chain_test();
    load_store_test();
    branch_test();
    jump_test();
    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    if (mismatch_count + fail_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+rtl
+incdir+testbench
rtl/riscv_isa_pkg.sv
rtl/pipe_pkg.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/riscv_pipeline.sv
testbench/tb_riscv_pipeline.sv

/* Makefile */
TOP := tb_riscv_pipeline

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/100ps \
	  --top-module $(TOP) -f all.f

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qxF '>>> PASS'

lint:
	verilator --lint-only --timing --timescale 1ns/100ps \
	  --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir
